//--- build.f
+incdir+testbench
common/overlay_pkg.sv
logic/name_rom.sv
logic/hp_digits.sv
logic/field_locate.sv
logic/char_select.sv
logic/text_overlay.sv
testbench/tb_text_overlay.sv

//--- Makefile
SRCS := $(shell grep -v '^+' build.f) testbench/tb_tests.svh

.PHONY: run clean

obj_dir/sim: build.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_text_overlay -f build.f -o sim

run: obj_dir/sim
	@out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -qx 'ALL TESTS PASSED'

clean:
	rm -rf obj_dir

//--- testbench/tb_tests.svh
// every pixel of every creature name
task automatic check_creature_names();
   overlay_pkg::pixel_req_t r;
   open_test();
   for (int id = 0; id < 8; id++) begin
      for (int y = 0; y < overlay_pkg::GLYPH_H; y++) begin
         for (int x = 0; x < FLEN[0] * overlay_pkg::GLYPH_W; x++) begin
            r         = pixel_at(FX[0] + x, FY[0] + y);
            r.poke_id = 3'(id);
            stim_q.push_back(r);
         end
      end
   end
   run_stream(0, 1'b0);
   close_test("creature names");
endtask

// random valid moves, random pixels inside the field
task automatic check_move_names();
   overlay_pkg::pixel_req_t r;
   open_test();
   for (int i = 0; i < MOVE_REQS; i++) begin
      r = pixel_at(FX[1] + random_below(FLEN[1] * overlay_pkg::GLYPH_W),
                   FY[1] + random_below(overlay_pkg::GLYPH_H));
      r.move_id = 5'(random_below(26));
      stim_q.push_back(r);
   end
   run_stream(0, 1'b0);
   close_test("move names");
endtask

// whole label, then a one pixel ring around every field
task automatic check_label_and_misses();
   int w;
   open_test();
   for (int y = 0; y < overlay_pkg::GLYPH_H; y++) begin
      for (int x = 0; x < FLEN[2] * overlay_pkg::GLYPH_W; x++) begin
         stim_q.push_back(pixel_at(FX[2] + x, FY[2] + y));
      end
   end
   for (int f = 0; f < 4; f++) begin
      w = FLEN[f] * overlay_pkg::GLYPH_W;
      for (int r = 0; r < overlay_pkg::GLYPH_H; r++) begin
         stim_q.push_back(pixel_at(FX[f] - 1, FY[f] + r));
         stim_q.push_back(pixel_at(FX[f] + w, FY[f] + r));
      end
      for (int c = 0; c < w; c++) begin
         stim_q.push_back(pixel_at(FX[f] + c, FY[f] - 1));
         stim_q.push_back(pixel_at(FX[f] + c, FY[f] + overlay_pkg::GLYPH_H));
      end
   end
   run_stream(0, 1'b0);
   close_test("label and misses");
endtask

// fixed corner pairs first, then random pairs
task automatic check_hp_value();
   int                      cur_fixed [5] = '{0, 5, 37, 100, 255};
   int                      max_fixed [5] = '{0, 50, 50, 100, 9};
   int                      cur;
   int                      max;
   overlay_pkg::pixel_req_t r;
   open_test();
   for (int i = 0; i < HP_PAIRS; i++) begin
      cur = (i < 5) ? cur_fixed[i] : random_below(256);
      max = (i < 5) ? max_fixed[i] : random_below(256);
      for (int s = 0; s < FLEN[3]; s++) begin
         r = pixel_at(FX[3] + s * overlay_pkg::GLYPH_W + random_below(8),
                      FY[3] + random_below(overlay_pkg::GLYPH_H));
         r.cur_hp = 8'(cur);
         r.max_hp = 8'(max);
         stim_q.push_back(r);
      end
   end
   run_stream(0, 1'b0);
   close_test("hp value");
endtask

// same stream twice, clean then with glyph_ready dropping 30% of cycles
task automatic check_back_pressure();
   overlay_pkg::glyph_out_t clean_q [$];
   open_test();
   for (int i = 0; i < BP_REQS; i++) begin
      stim_q.push_back(random_request());
   end
   run_stream(0, 1'b0);
   clean_q = got_q;
   run_stream(30, 1'b0);
   for (int i = 0; i < clean_q.size(); i++) begin
      assert (got_q[i] == clean_q[i]) else begin
         $display("[FAIL] glyph got %h exp %h, stalled run request %0d",
                  got_q[i], clean_q[i], i);
         err_cnt++;
      end
   end
   close_test("back-pressure");
endtask

// ready held high, every result two cycles after acceptance
task automatic check_latency();
   open_test();
   for (int i = 0; i < LAT_REQS; i++) begin
      stim_q.push_back(random_request());
   end
   run_stream(0, 1'b1);
   close_test("latency");
endtask

//--- testbench/tb_text_overlay.sv
`timescale 1ns/1ps

module tb_text_overlay;

   // field origins and lengths, index order is the priority order
   localparam int FX [4]   = '{16, 16, 400, 432};
   localparam int FY [4]   = '{16, 400, 16, 16};
   localparam int FLEN [4] = '{9, 12, 2, 7};

   // requests per test
   localparam int NAME_REQS  = 8 * 9 * 8 * 16;
   localparam int MOVE_REQS  = 400;
   localparam int LABEL_REQS = 16 * 16 + 4 * 2 * 16 + 2 * (9 + 12 + 2 + 7) * 8;
   localparam int HP_PAIRS   = 26;
   localparam int VALUE_REQS = HP_PAIRS * 7;
   localparam int BP_REQS    = 500;
   localparam int LAT_REQS   = 200;
   // stalled stream weighted double on top of its clean run
   localparam int NUM_REQS   = NAME_REQS + MOVE_REQS + LABEL_REQS + VALUE_REQS
                               + 3 * BP_REQS + LAT_REQS;

   logic                    clk;
   logic                    rst_n;
   overlay_pkg::pixel_req_t req;
   logic                    req_valid;
   logic                    req_ready;
   overlay_pkg::glyph_out_t glyph;
   logic                    glyph_valid;
   logic                    glyph_ready;

   logic [31:0] rng_state;
   int          err_cnt;
   int          tests_ok;
   int          tests_bad;
   int          test_err_base;

   // pixels of the current test and the results in arrival order
   overlay_pkg::pixel_req_t stim_q [$];
   overlay_pkg::glyph_out_t got_q [$];

   // expected text, unpadded
   string name_list [8] = '{"BLASTOISE", "CHARIZARD", "DRAGONITE", "GENGAR",
                            "MEW", "PIKACHU", "VENUSAUR", "WEEZING"};
   string move_list [26] = '{"HYDRO PUMP", "ICE BEAM", "CRUNCH", "AURA SPHERE",
                             "FLAMETHROWER", "THUNDERPUNCH", "AIR SLASH", "DRAGON CLAW",
                             "ENERGY BALL", "SLUDGE BOMB", "EARTHQUAKE", "PETAL DANCE",
                             "THUNDERBOLT", "SLAM", "SURF", "THUNDER", "DARK PULSE",
                             "SHADOW BALL", "PSYCHIC", "PLAY ROUGH", "FLASH CANNON",
                             "BUG BUZZ", "FIRE BLAST", "ROCK SLIDE", "DRAGON PULSE",
                             "BLIZZARD"};

   text_overlay #(
      .NAME_X  (10'(FX[0])),
      .NAME_Y  (10'(FY[0])),
      .MOVE_X  (10'(FX[1])),
      .MOVE_Y  (10'(FY[1])),
      .LABEL_X (10'(FX[2])),
      .LABEL_Y (10'(FY[2])),
      .VALUE_X (10'(FX[3])),
      .VALUE_Y (10'(FY[3]))
   ) text_overlay_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .req         (req),
      .req_valid   (req_valid),
      .req_ready   (req_ready),
      .glyph       (glyph),
      .glyph_valid (glyph_valid),
      .glyph_ready (glyph_ready)
   );

   always #5 clk = ~clk;

   // xorshift32
   function automatic logic [31:0] next_random();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   function automatic int random_below(input int n);
      return int'(next_random() % 32'(n));
   endfunction

   // pixel with random battle state, ids up to 31 so unused moves show up too
   function automatic overlay_pkg::pixel_req_t pixel_at(input int x, input int y);
      overlay_pkg::pixel_req_t r;
      r.x       = 10'(x);
      r.y       = 10'(y);
      r.poke_id = 3'(random_below(8));
      r.move_id = 5'(random_below(32));
      r.cur_hp  = 8'(random_below(256));
      r.max_hp  = 8'(random_below(256));
      return r;
   endfunction

   // somewhere in or just around a random field
   function automatic overlay_pkg::pixel_req_t random_request();
      int f;
      int w;
      f = random_below(4);
      w = FLEN[f] * overlay_pkg::GLYPH_W;
      return pixel_at(FX[f] - 8 + random_below(w + 16), FY[f] - 4 + random_below(24));
   endfunction

   // blank past the end of the text
   function automatic overlay_pkg::char_code_t text_char(input string s, input int idx);
      if (idx < s.len()) begin
         return 8'(s.getc(idx));
      end
      return 8'h20;
   endfunction

   function automatic overlay_pkg::char_code_t field_char(input int f, input int slot,
                                                          input overlay_pkg::pixel_req_t p);
      case (f)
         0:       return text_char(name_list[p.poke_id], slot);
         1:       return (int'(p.move_id) < 26) ? text_char(move_list[p.move_id], slot) : 8'h20;
         2:       return (slot == 0) ? 8'h48 : 8'h50;
         // right aligned %3d gives the leading blanks
         default: return text_char($sformatf("%3d/%3d", p.cur_hp, p.max_hp), slot);
      endcase
   endfunction

   // reference model, walks the fields backwards so the first one wins
   function automatic overlay_pkg::glyph_out_t expected_glyph(input overlay_pkg::pixel_req_t p);
      overlay_pkg::glyph_out_t g;
      int dx;
      int dy;
      g.hit       = 1'b0;
      g.char_code = 8'h20;
      g.col       = '0;
      g.row       = '0;
      for (int f = 3; f >= 0; f--) begin
         dx = int'(p.x) - FX[f];
         dy = int'(p.y) - FY[f];
         if (dx >= 0 && dx < FLEN[f] * 8 && dy >= 0 && dy < 16) begin
            g.hit       = 1'b1;
            g.col       = 3'(dx % 8);
            g.row       = 4'(dy);
            g.char_code = field_char(f, dx / 8, p);
         end
      end
      return g;
   endfunction

   // sends stim_q, collects into got_q; handshakes sampled at negedge
   task automatic run_stream(input int stall_pct, input bit check_lat);
      int                      n;
      int                      sent;
      int                      got;
      int                      cyc;
      int                      lat;
      bit                      stalled;
      overlay_pkg::glyph_out_t held;
      overlay_pkg::glyph_out_t exp_g;
      int                      acc_q [$];
      n       = stim_q.size();
      sent    = 0;
      got     = 0;
      cyc     = 0;
      stalled = 1'b0;
      held    = '0;
      got_q.delete();
      while (got < n) begin
         @(posedge clk);
         #1;
         req_valid = (sent < n);
         if (sent < n) begin
            req = stim_q[sent];
         end
         glyph_ready = (random_below(100) >= stall_pct);
         @(negedge clk);
         // output under a stall must hold
         if (stalled) begin
            assert (glyph_valid && glyph == held) else begin
               $display("glyph dropped or changed while glyph_ready was low, cycle %0d", cyc);
               err_cnt++;
            end
         end
         stalled = glyph_valid && !glyph_ready;
         held    = glyph;
         if (req_valid && req_ready) begin
            acc_q.push_back(cyc);
            sent++;
         end
         if (glyph_valid && glyph_ready) begin
            exp_g = expected_glyph(stim_q[got]);
            lat   = cyc - acc_q.pop_front();
            assert (glyph == exp_g) else begin
               $display("[FAIL] glyph got %h exp %h, request %0d", glyph, exp_g, got);
               err_cnt++;
            end
            if (check_lat) begin
               assert (lat == 2) else begin
                  $display("[FAIL] latency got %h exp %h, request %0d", lat, 2, got);
                  err_cnt++;
               end
            end
            got_q.push_back(glyph);
            got++;
         end
         cyc++;
      end
   endtask

   task automatic open_test();
      test_err_base = err_cnt;
      stim_q.delete();
   endtask

   task automatic close_test(input string name);
      if (err_cnt == test_err_base) begin
         tests_ok++;
         $display("test %s: ok, %0d requests", name, stim_q.size());
      end else begin
         tests_bad++;
         $display("test %s: failed with %0d errors", name, err_cnt - test_err_base);
      end
   endtask

   `include "tb_tests.svh"

   // ends a run that stopped making progress
   initial begin
      #((NUM_REQS + 100) * 10);
      $display("timeout, the DUT did not deliver all results in time");
      $display("SOME TESTS FAILED");
      $finish;
   end

   initial begin
      clk           = 1'b0;
      rst_n         = 1'b0;
      req           = '0;
      req_valid     = 1'b0;
      glyph_ready   = 1'b0;
      rng_state     = 32'd42;
      err_cnt       = 0;
      tests_ok      = 0;
      tests_bad     = 0;
      test_err_base = 0;
      repeat (4) @(posedge clk);
      #1;
      rst_n = 1'b1;
      @(negedge clk);
      assert (req_ready && !glyph_valid) else begin
         $display("after reset req_ready is not high or glyph_valid is not low");
         err_cnt++;
      end
      check_creature_names();
      check_move_names();
      check_label_and_misses();
      check_hp_value();
      check_back_pressure();
      check_latency();
      $display("tests run %0d, ok %0d, failed %0d, errors %0d",
               tests_ok + tests_bad, tests_ok, tests_bad, err_cnt);
      if (tests_bad == 0 && err_cnt == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

//--- logic/text_overlay.sv
`timescale 1ns/1ps

module text_overlay #(
   parameter overlay_pkg::coord_t NAME_X  = 10'd16,
   parameter overlay_pkg::coord_t NAME_Y  = 10'd16,
   parameter overlay_pkg::coord_t MOVE_X  = 10'd16,
   parameter overlay_pkg::coord_t MOVE_Y  = 10'd400,
   parameter overlay_pkg::coord_t LABEL_X = 10'd400,
   parameter overlay_pkg::coord_t LABEL_Y = 10'd16,
   parameter overlay_pkg::coord_t VALUE_X = 10'd432,
   parameter overlay_pkg::coord_t VALUE_Y = 10'd16
) (
   input  logic                    clk,
   input  logic                    rst_n,
   input  overlay_pkg::pixel_req_t req,
   input  logic                    req_valid,
   output logic                    req_ready,
   output overlay_pkg::glyph_out_t glyph,
   output logic                    glyph_valid,
   input  logic                    glyph_ready
);

   // stage 1 to stage 2 link
   overlay_pkg::located_t loc;
   logic                  loc_valid;
   logic                  loc_ready;

   // positions only matter to the locate stage
   field_locate #(
      .NAME_X  (NAME_X),
      .NAME_Y  (NAME_Y),
      .MOVE_X  (MOVE_X),
      .MOVE_Y  (MOVE_Y),
      .LABEL_X (LABEL_X),
      .LABEL_Y (LABEL_Y),
      .VALUE_X (VALUE_X),
      .VALUE_Y (VALUE_Y)
   ) field_locate_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .req       (req),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .loc       (loc),
      .loc_valid (loc_valid),
      .loc_ready (loc_ready)
   );

   // character pick and output register
   char_select char_select_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .loc         (loc),
      .loc_valid   (loc_valid),
      .loc_ready   (loc_ready),
      .glyph       (glyph),
      .glyph_valid (glyph_valid),
      .glyph_ready (glyph_ready)
   );

endmodule

//--- logic/char_select.sv
`timescale 1ns/1ps

module char_select (
   input  logic                    clk,
   input  logic                    rst_n,
   input  overlay_pkg::located_t   loc,
   input  logic                    loc_valid,
   output logic                    loc_ready,
   output overlay_pkg::glyph_out_t glyph,
   output logic                    glyph_valid,
   input  logic                    glyph_ready
);

   // the fixed label text
   localparam overlay_pkg::char_code_t CHAR_H = 8'h48;
   localparam overlay_pkg::char_code_t CHAR_P = 8'h50;

   overlay_pkg::char_code_t name_char;
   overlay_pkg::char_code_t move_char;
   overlay_pkg::char_code_t value_char;
   overlay_pkg::glyph_out_t glyph_next;

   // both tables looked up every cycle and field picks one below
   name_rom name_rom_i (
      .poke_id   (loc.poke_id),
      .move_id   (loc.move_id),
      .slot      (loc.slot),
      .name_char (name_char),
      .move_char (move_char)
   );

   hp_digits hp_digits_i (
      .cur_hp     (loc.cur_hp),
      .max_hp     (loc.max_hp),
      .slot       (loc.slot),
      .value_char (value_char)
   );

   always_comb begin
      glyph_next.hit = (loc.field != overlay_pkg::FIELD_NONE);
      // col and row already zero on a miss from stage 1
      glyph_next.col = loc.col;
      glyph_next.row = loc.row;
      case (loc.field)
         overlay_pkg::FIELD_NAME:  glyph_next.char_code = name_char;
         overlay_pkg::FIELD_MOVE:  glyph_next.char_code = move_char;
         overlay_pkg::FIELD_LABEL: glyph_next.char_code = (loc.slot == '0) ? CHAR_H : CHAR_P;
         overlay_pkg::FIELD_VALUE: glyph_next.char_code = value_char;
         // a miss gives a blank in every field
         default:                  glyph_next.char_code = overlay_pkg::CHAR_SPACE;
      endcase
   end

   // same skid-free rule as stage 1
   assign loc_ready = !glyph_valid || glyph_ready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         glyph_valid <= 1'b0;
      end else if (loc_ready) begin
         glyph_valid <= loc_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (loc_valid && loc_ready) begin
         glyph <= glyph_next;
      end
   end

   // a miss carries neither a visible character nor a glyph position
   a_miss_blank: assert property (@(posedge clk) disable iff (!rst_n)
      glyph_valid && !glyph.hit |-> glyph.char_code == overlay_pkg::CHAR_SPACE
         && glyph.col == '0 && glyph.row == '0);

endmodule

//--- logic/field_locate.sv
`timescale 1ns/1ps

module field_locate #(
   parameter overlay_pkg::coord_t NAME_X  = 10'd16,
   parameter overlay_pkg::coord_t NAME_Y  = 10'd16,
   parameter overlay_pkg::coord_t MOVE_X  = 10'd16,
   parameter overlay_pkg::coord_t MOVE_Y  = 10'd400,
   parameter overlay_pkg::coord_t LABEL_X = 10'd400,
   parameter overlay_pkg::coord_t LABEL_Y = 10'd16,
   parameter overlay_pkg::coord_t VALUE_X = 10'd432,
   parameter overlay_pkg::coord_t VALUE_Y = 10'd16
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  overlay_pkg::pixel_req_t req,
   input  logic                   req_valid,
   output logic                   req_ready,
   output overlay_pkg::located_t  loc,
   output logic                   loc_valid,
   input  logic                   loc_ready
);

   // box test, one bit wider so field ends near 1023 do not wrap
   function automatic logic in_box(input overlay_pkg::coord_t px,
                                   input overlay_pkg::coord_t py,
                                   input overlay_pkg::coord_t bx,
                                   input overlay_pkg::coord_t by,
                                   input int len);
      logic [10:0] x_end;
      logic [10:0] y_end;
      x_end = {1'b0, bx} + 11'(len * overlay_pkg::GLYPH_W);
      y_end = {1'b0, by} + 11'(overlay_pkg::GLYPH_H);
      return (px >= bx) && ({1'b0, px} < x_end) && (py >= by) && ({1'b0, py} < y_end);
   endfunction

   overlay_pkg::field_e   field;
   overlay_pkg::coord_t   base_x;
   overlay_pkg::coord_t   base_y;
   overlay_pkg::coord_t   dx;
   overlay_pkg::coord_t   dy;
   overlay_pkg::located_t loc_next;

   // priority order name, move, label, value
   always_comb begin
      field  = overlay_pkg::FIELD_NONE;
      base_x = '0;
      base_y = '0;
      if (in_box(req.x, req.y, NAME_X, NAME_Y, overlay_pkg::NAME_LEN)) begin
         field  = overlay_pkg::FIELD_NAME;
         base_x = NAME_X;
         base_y = NAME_Y;
      end else if (in_box(req.x, req.y, MOVE_X, MOVE_Y, overlay_pkg::MOVE_LEN)) begin
         field  = overlay_pkg::FIELD_MOVE;
         base_x = MOVE_X;
         base_y = MOVE_Y;
      end else if (in_box(req.x, req.y, LABEL_X, LABEL_Y, overlay_pkg::HP_LABEL_LEN)) begin
         field  = overlay_pkg::FIELD_LABEL;
         base_x = LABEL_X;
         base_y = LABEL_Y;
      end else if (in_box(req.x, req.y, VALUE_X, VALUE_Y, overlay_pkg::HP_VALUE_LEN)) begin
         field  = overlay_pkg::FIELD_VALUE;
         base_x = VALUE_X;
         base_y = VALUE_Y;
      end
   end

   // one shared subtractor pair for all fields
   assign dx = req.x - base_x;
   assign dy = req.y - base_y;

   always_comb begin
      loc_next         = '0;
      loc_next.field   = field;
      loc_next.poke_id = req.poke_id;
      loc_next.move_id = req.move_id;
      loc_next.cur_hp  = req.cur_hp;
      loc_next.max_hp  = req.max_hp;
      // misses keep slot, col and row at zero
      if (field != overlay_pkg::FIELD_NONE) begin
         // cell is 8 wide, so slot and col are just bit fields of dx
         loc_next.slot = dx[6:3];
         loc_next.col  = dx[2:0];
         loc_next.row  = dy[3:0];
      end
   end

   // stage can take a new pixel when empty or draining this cycle
   assign req_ready = !loc_valid || loc_ready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         loc_valid <= 1'b0;
      end else if (req_ready) begin
         loc_valid <= req_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (req_valid && req_ready) begin
         loc <= loc_next;
      end
   end

   // stalled output must not change under char_select
   a_loc_hold: assert property (@(posedge clk) disable iff (!rst_n)
      loc_valid && !loc_ready |=> loc_valid && $stable(loc));

endmodule

//--- logic/hp_digits.sv
`timescale 1ns/1ps

module hp_digits (
   input  overlay_pkg::hp_t        cur_hp,
   input  overlay_pkg::hp_t        max_hp,
   input  overlay_pkg::slot_t      slot,
   output overlay_pkg::char_code_t value_char
);

   // three characters, hundreds in the top byte
   function automatic logic [23:0] num_text(input overlay_pkg::hp_t v);
      overlay_pkg::hp_t        hun;
      overlay_pkg::hp_t        ten;
      overlay_pkg::hp_t        one;
      overlay_pkg::char_code_t c_hun;
      overlay_pkg::char_code_t c_ten;
      overlay_pkg::char_code_t c_one;
      hun   = v / 8'd100;
      ten   = (v / 8'd10) % 8'd10;
      one   = v % 8'd10;
      c_hun = (hun == '0) ? overlay_pkg::CHAR_SPACE : hun + overlay_pkg::CHAR_ZERO;
      // leading zero in tens only blanked when hundreds was blank too
      c_ten = (hun == '0 && ten == '0) ? overlay_pkg::CHAR_SPACE : ten + overlay_pkg::CHAR_ZERO;
      // units always drawn, so 0 shows as "  0"
      c_one = one + overlay_pkg::CHAR_ZERO;
      return {c_hun, c_ten, c_one};
   endfunction

   logic [23:0] cur_text;
   logic [23:0] max_text;

   assign cur_text = num_text(cur_hp);
   assign max_text = num_text(max_hp);

   // layout is ccc/mmm
   always_comb begin
      case (slot)
         4'd0:    value_char = cur_text[23:16];
         4'd1:    value_char = cur_text[15:8];
         4'd2:    value_char = cur_text[7:0];
         4'd3:    value_char = overlay_pkg::CHAR_SLASH;
         4'd4:    value_char = max_text[23:16];
         4'd5:    value_char = max_text[15:8];
         4'd6:    value_char = max_text[7:0];
         default: value_char = overlay_pkg::CHAR_SPACE;
      endcase
   end

endmodule

//--- logic/name_rom.sv
`timescale 1ns/1ps

module name_rom (
   input  overlay_pkg::poke_id_t   poke_id,
   input  overlay_pkg::move_id_t   move_id,
   input  overlay_pkg::slot_t      slot,
   output overlay_pkg::char_code_t name_char,
   output overlay_pkg::char_code_t move_char
);

   localparam int NUM_POKES = 8;
   localparam int NUM_MOVES = 26;

   // first character sits in the top byte, short names padded with blanks
   localparam logic [0:overlay_pkg::NAME_LEN-1][7:0] NAME_TAB [0:NUM_POKES-1] = '{
      "BLASTOISE",
      "CHARIZARD",
      "DRAGONITE",
      "GENGAR   ",
      "MEW      ",
      "PIKACHU  ",
      "VENUSAUR ",
      "WEEZING  "
   };

   // move table, index is move_id
   localparam logic [0:overlay_pkg::MOVE_LEN-1][7:0] MOVE_TAB [0:NUM_MOVES-1] = '{
      "HYDRO PUMP  ",
      "ICE BEAM    ",
      "CRUNCH      ",
      "AURA SPHERE ",
      "FLAMETHROWER",
      "THUNDERPUNCH",
      "AIR SLASH   ",
      "DRAGON CLAW ",
      "ENERGY BALL ",
      "SLUDGE BOMB ",
      "EARTHQUAKE  ",
      "PETAL DANCE ",
      "THUNDERBOLT ",
      "SLAM        ",
      "SURF        ",
      "THUNDER     ",
      "DARK PULSE  ",
      "SHADOW BALL ",
      "PSYCHIC     ",
      "PLAY ROUGH  ",
      "FLASH CANNON",
      "BUG BUZZ    ",
      "FIRE BLAST  ",
      "ROCK SLIDE  ",
      "DRAGON PULSE",
      "BLIZZARD    "
   };

   // poke_id covers all 8 entries, only the slot needs a range check
   always_comb begin
      if (int'(slot) < overlay_pkg::NAME_LEN) begin
         name_char = NAME_TAB[poke_id][slot];
      end else begin
         name_char = overlay_pkg::CHAR_SPACE;
      end
   end

   // ids 26..31 are unused and read as blank
   always_comb begin
      if (int'(move_id) < NUM_MOVES && int'(slot) < overlay_pkg::MOVE_LEN) begin
         move_char = MOVE_TAB[move_id][slot];
      end else begin
         move_char = overlay_pkg::CHAR_SPACE;
      end
   end

endmodule

//--- common/overlay_pkg.sv
package overlay_pkg;

   // screen position, 640x480 fits in 10 bits
   typedef logic [9:0] coord_t;

   // pixel position inside one glyph cell
   typedef logic [2:0] col_t;
   typedef logic [3:0] row_t;

   // ascii code sent to the font lookup
   typedef logic [7:0] char_code_t;

   // character index inside a field, longest field has 12
   typedef logic [3:0] slot_t;

   // creature and move selectors
   typedef logic [2:0] poke_id_t;
   typedef logic [4:0] move_id_t;

   // hit points, up to 255
   typedef logic [7:0] hp_t;

   // glyph cell size in pixels
   localparam int GLYPH_W = 8;
   localparam int GLYPH_H = 16;

   // field lengths in characters
   localparam int NAME_LEN     = 9;
   localparam int MOVE_LEN     = 12;
   localparam int HP_LABEL_LEN = 2;
   // "ccc/mmm"
   localparam int HP_VALUE_LEN = 7;

   localparam char_code_t CHAR_SPACE = 8'h20;
   localparam char_code_t CHAR_ZERO  = 8'h30;
   localparam char_code_t CHAR_SLASH = 8'h2f;

   // which text field a pixel landed in
   typedef enum logic [2:0] {
      FIELD_NONE,
      FIELD_NAME,
      FIELD_MOVE,
      FIELD_LABEL,
      FIELD_VALUE
   } field_e;

   // one pixel to classify, plus the battle state it is drawn with
   typedef struct packed {
      coord_t   x;
      coord_t   y;
      poke_id_t poke_id;
      move_id_t move_id;
      hp_t      cur_hp;
      hp_t      max_hp;
   } pixel_req_t;

   // stage 1 result, ids and hp ride along for stage 2
   typedef struct packed {
      field_e   field;
      slot_t    slot;
      col_t     col;
      row_t     row;
      poke_id_t poke_id;
      move_id_t move_id;
      hp_t      cur_hp;
      hp_t      max_hp;
   } located_t;

   // per pixel answer for the glyph renderer
   typedef struct packed {
      logic       hit;
      char_code_t char_code;
      col_t       col;
      row_t       row;
   } glyph_out_t;

endpackage
